// File: logic/axi_bridge_pkg.sv
`default_nettype none

package axi_bridge_pkg;

	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;
	localparam int LINE_W = 512; // one dcache line of 16 words

	// AXI burst types
	localparam logic [1:0] BURST_FIXED = 2'b00;
	localparam logic [1:0] BURST_INCR = 2'b01;

	localparam logic [2:0] SIZE_WORD = 3'b010; // 4 bytes per beat

	typedef enum logic [1:0]
	{
		RD_FREE = 2'd0,
		RD_REQ = 2'd1,
		RD_RES = 2'd2,
		RD_FINISH = 2'd3
	} rd_state_t;

	typedef enum logic [2:0]
	{
		WR_FREE = 3'd0,
		WR_REQ = 3'd1,
		WR_DATA = 3'd2,
		WR_RES = 3'd3,
		WR_FINISH = 3'd4
	} wr_state_t;

endpackage

`default_nettype wire

// File: logic/cache_rd_if.sv
`default_nettype none

interface cache_rd_if;
	import axi_bridge_pkg::*;

	logic req; // level held until rdy
	logic [ADDR_W-1:0] addr;
	logic rdy;
	logic ret_valid;
	logic ret_last;
	logic [DATA_W-1:0] ret_data;

	modport cache
	(
		output req,
		output addr,
		input rdy,
		input ret_valid,
		input ret_last,
		input ret_data
	);

	modport bridge
	(
		input req,
		input addr,
		output rdy,
		output ret_valid,
		output ret_last,
		output ret_data
	);

endinterface

`default_nettype wire

// File: logic/wr_ctrl_if.sv
`default_nettype none

interface wr_ctrl_if;

	logic load; // buffer capture during all of WR_REQ
	logic in_data; // data phase
	logic beat_ok; // wvalid and wready
	logic uncached; // single word write to config space
	logic last_beat;

	modport fsm
	(
		output load,
		output in_data,
		output beat_ok,
		output uncached,
		input last_beat
	);

	modport counter
	(
		input in_data,
		input beat_ok,
		output last_beat
	);

	modport buffer
	(
		input load,
		input beat_ok,
		input uncached
	);

endinterface

`default_nettype wire

// File: logic/rd_fsm.sv
`default_nettype none

module rd_fsm #(
	parameter int LINE_WORDS = 16
) (
	input wire clk,
	input wire rst,
	input wire conf_sel,
	cache_rd_if.bridge ic,
	cache_rd_if.bridge dc,
	output logic [3:0] arid,
	output logic [axi_bridge_pkg::ADDR_W-1:0] araddr,
	output logic [3:0] arlen,
	output logic [1:0] arburst,
	output logic arvalid,
	input wire arready,
	input wire [3:0] rid,
	input wire [axi_bridge_pkg::DATA_W-1:0] rdata,
	input wire rlast,
	input wire rvalid
);
	import axi_bridge_pkg::*;

	rd_state_t state;
	rd_state_t state_nx;
	logic idle;
	logic take;
	logic sel_dc; // 0 icache, 1 dcache
	logic single; // config space read of one beat
	logic [ADDR_W-1:0] addr_q;

	assign idle = (state == RD_FREE) || (state == RD_FINISH);

	// a request is taken in the same cycle the cache sees rdy
	assign ic.rdy = idle && arready;
	assign dc.rdy = idle && arready && !ic.req; // icache first
	assign take = idle && arready && (ic.req || dc.req);

	always_ff @(posedge clk)
	begin
		if (!rst)
			state <= RD_FREE;
		else
			state <= state_nx;
	end

	always_comb
	begin
		state_nx = state;
		case (state)
			RD_FREE, RD_FINISH:
				if (take)
					state_nx = RD_REQ;
			RD_REQ:
				if (arready)
					state_nx = RD_RES;
			RD_RES:
				if (rvalid && rlast) // rready is tied high
					state_nx = RD_FINISH;
		endcase
	end

	// the cache may drop req after rdy, so keep the choice
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			sel_dc <= 1'b0;
			single <= 1'b0;
		end
		else if (take)
		begin
			sel_dc <= !ic.req;
			single <= !ic.req && conf_sel;
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
			addr_q <= ic.req ? ic.addr : dc.addr;
	end

	assign arid = {3'b000, sel_dc};
	assign araddr = addr_q;
	assign arlen = single ? 4'd0 : 4'(LINE_WORDS - 1);
	assign arburst = single ? BURST_FIXED : BURST_INCR;
	assign arvalid = (state == RD_REQ);

	// rid[0] names the port of the return
	assign ic.ret_valid = rvalid && !rid[0];
	assign ic.ret_last = rvalid && rlast && !rid[0];
	assign ic.ret_data = rdata;
	assign dc.ret_valid = rvalid && rid[0];
	assign dc.ret_last = rvalid && rlast && rid[0];
	assign dc.ret_data = rdata;

endmodule

`default_nettype wire

// File: logic/wr_fsm.sv
`default_nettype none

module wr_fsm #(
	parameter int LINE_WORDS = 16
) (
	input wire clk,
	input wire rst,
	input wire conf_sel,
	input wire wr_req,
	input wire awready,
	input wire wready,
	input wire bvalid,
	output logic awvalid,
	output logic wvalid,
	output logic wlast,
	output logic [3:0] awlen,
	output logic [1:0] awburst,
	output logic wr_rdy,
	wr_ctrl_if.fsm ctrl
);
	import axi_bridge_pkg::*;

	wr_state_t state;
	wr_state_t state_nx;
	logic idle;
	logic take;
	logic uncached;
	logic beat_ok;
	logic final_beat;

	assign idle = (state == WR_FREE) || (state == WR_FINISH);
	assign wr_rdy = idle && awready;
	assign take = wr_rdy && wr_req;

	assign beat_ok = wvalid && wready;
	assign final_beat = uncached || ctrl.last_beat; // one word when uncached

	always_ff @(posedge clk)
	begin
		if (!rst)
			state <= WR_FREE;
		else
			state <= state_nx;
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
			uncached <= 1'b0;
		else if (take)
			uncached <= conf_sel; // write mode for the whole burst
	end

	always_comb
	begin
		state_nx = state;
		case (state)
			WR_FREE, WR_FINISH:
				if (take)
					state_nx = WR_REQ;
			WR_REQ:
				if (awready)
					state_nx = WR_DATA;
			WR_DATA:
				if (beat_ok && final_beat)
					state_nx = WR_RES;
			WR_RES:
				if (bvalid) // bready tied high
					state_nx = WR_FINISH;
			default:
				state_nx = WR_FREE;
		endcase
	end

	assign awvalid = (state == WR_REQ);
	assign awlen = uncached ? 4'd0 : 4'(LINE_WORDS - 1);
	assign awburst = uncached ? BURST_FIXED : BURST_INCR;
	assign wvalid = (state == WR_DATA);
	assign wlast = wvalid && final_beat;

	assign ctrl.load = (state == WR_REQ);
	assign ctrl.in_data = (state == WR_DATA);
	assign ctrl.beat_ok = beat_ok;
	assign ctrl.uncached = uncached;

endmodule

`default_nettype wire

// File: logic/beat_counter.sv
`default_nettype none

module beat_counter #(
	parameter int LINE_WORDS = 16
) (
	input wire clk,
	input wire rst,
	wr_ctrl_if.counter ctrl
);

	localparam int CNT_W = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1;

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk)
	begin
		if (!rst)
			cnt <= '0;
		else if (!ctrl.in_data)
			cnt <= '0; // cleared outside the data phase
		else if (ctrl.beat_ok)
			cnt <= cnt + 1'b1;
	end

	// holds while wready is low
	assign ctrl.last_beat = (cnt == CNT_W'(LINE_WORDS - 1));

endmodule

`default_nettype wire

// File: logic/wr_line_buffer.sv
`default_nettype none

module wr_line_buffer #(
	parameter int LINE_WORDS = 16
) (
	input wire clk,
	input wire rst,
	input wire [LINE_WORDS*axi_bridge_pkg::DATA_W-1:0] line_in,
	input wire [axi_bridge_pkg::DATA_W-1:0] word_in,
	output logic [axi_bridge_pkg::DATA_W-1:0] wdata,
	wr_ctrl_if.buffer ctrl
);
	import axi_bridge_pkg::*;

	localparam int BUF_W = LINE_WORDS * DATA_W;

	logic [BUF_W-1:0] line_q;
	logic [DATA_W-1:0] word_q;

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			line_q <= '0;
			word_q <= '0;
		end
		else if (ctrl.load)
		begin
			line_q <= line_in;
			word_q <= word_in;
		end
		else if (ctrl.beat_ok)
			line_q <= line_q >> DATA_W; // next word down to the bottom
	end

	// lowest word goes out first
	assign wdata = ctrl.uncached ? word_q : line_q[DATA_W-1:0];

endmodule

`default_nettype wire

// File: logic/axi_sram_bridge.sv
`default_nettype none

module axi_sram_bridge #(
	parameter int LINE_WORDS = axi_bridge_pkg::LINE_W / axi_bridge_pkg::DATA_W
) (
	input wire clk,
	input wire rst, // low active
	input wire conf_sel,
	// read address
	output logic [3:0] arid,
	output logic [axi_bridge_pkg::ADDR_W-1:0] araddr,
	output logic [3:0] arlen,
	output logic [2:0] arsize,
	output logic [1:0] arburst,
	output logic [1:0] arlock,
	output logic [3:0] arcache,
	output logic [2:0] arprot,
	output logic arvalid,
	input wire arready,
	// read data
	input wire [3:0] rid,
	input wire [axi_bridge_pkg::DATA_W-1:0] rdata,
	input wire rlast,
	input wire rvalid,
	output logic rready,
	// write address
	output logic [3:0] awid,
	output logic [axi_bridge_pkg::ADDR_W-1:0] awaddr,
	output logic [3:0] awlen,
	output logic [2:0] awsize,
	output logic [1:0] awburst,
	output logic [1:0] awlock,
	output logic [3:0] awcache,
	output logic [2:0] awprot,
	output logic awvalid,
	input wire awready,
	// write data and response
	output logic [3:0] wid,
	output logic [axi_bridge_pkg::DATA_W-1:0] wdata,
	output logic [3:0] wstrb,
	output logic wlast,
	output logic wvalid,
	input wire wready,
	input wire bvalid,
	output logic bready,
	// icache read
	input wire ic_rd_req,
	input wire [axi_bridge_pkg::ADDR_W-1:0] ic_rd_addr,
	output logic ic_rd_rdy,
	output logic ic_ret_valid,
	output logic ic_ret_last,
	output logic [axi_bridge_pkg::DATA_W-1:0] ic_ret_data,
	// dcache read
	input wire dc_rd_req,
	input wire [axi_bridge_pkg::ADDR_W-1:0] dc_rd_addr,
	output logic dc_rd_rdy,
	output logic dc_ret_valid,
	output logic dc_ret_last,
	output logic [axi_bridge_pkg::DATA_W-1:0] dc_ret_data,
	// dcache write
	input wire dc_wr_req,
	input wire [axi_bridge_pkg::ADDR_W-1:0] dc_wr_addr,
	input wire [3:0] dc_wr_wstrb,
	input wire [LINE_WORDS*axi_bridge_pkg::DATA_W-1:0] dc_wr_data,
	input wire [axi_bridge_pkg::DATA_W-1:0] dc_uncache_wr_data,
	output logic dc_wr_rdy
);
	import axi_bridge_pkg::*;

	cache_rd_if ic_if ();
	cache_rd_if dc_if ();
	wr_ctrl_if wr_ctrl ();

	// fixed AXI fields
	assign arsize = SIZE_WORD;
	assign arlock = 2'b00;
	assign arcache = 4'b0000;
	assign arprot = 3'b000;
	assign rready = 1'b1;
	assign awid = 4'd1;
	assign awsize = SIZE_WORD;
	assign awlock = 2'b00;
	assign awcache = 4'b0000;
	assign awprot = 3'b000;
	assign wid = 4'd1;
	assign bready = 1'b1;

	assign awaddr = dc_wr_addr;
	assign wstrb = dc_wr_wstrb;

	assign ic_if.req = ic_rd_req;
	assign ic_if.addr = ic_rd_addr;
	assign ic_rd_rdy = ic_if.rdy;
	assign ic_ret_valid = ic_if.ret_valid;
	assign ic_ret_last = ic_if.ret_last;
	assign ic_ret_data = ic_if.ret_data;

	assign dc_if.req = dc_rd_req;
	assign dc_if.addr = dc_rd_addr;
	assign dc_rd_rdy = dc_if.rdy;
	assign dc_ret_valid = dc_if.ret_valid;
	assign dc_ret_last = dc_if.ret_last;
	assign dc_ret_data = dc_if.ret_data;

	rd_fsm #(.LINE_WORDS(LINE_WORDS)) u_rd_fsm (
		.clk(clk),
		.rst(rst),
		.conf_sel(conf_sel),
		.ic(ic_if),
		.dc(dc_if),
		.arid(arid),
		.araddr(araddr),
		.arlen(arlen),
		.arburst(arburst),
		.arvalid(arvalid),
		.arready(arready),
		.rid(rid),
		.rdata(rdata),
		.rlast(rlast),
		.rvalid(rvalid)
	);

	wr_fsm #(.LINE_WORDS(LINE_WORDS)) u_wr_fsm (
		.clk(clk),
		.rst(rst),
		.conf_sel(conf_sel),
		.wr_req(dc_wr_req),
		.awready(awready),
		.wready(wready),
		.bvalid(bvalid),
		.awvalid(awvalid),
		.wvalid(wvalid),
		.wlast(wlast),
		.awlen(awlen),
		.awburst(awburst),
		.wr_rdy(dc_wr_rdy),
		.ctrl(wr_ctrl)
	);

	beat_counter #(.LINE_WORDS(LINE_WORDS)) u_beat_counter (
		.clk(clk),
		.rst(rst),
		.ctrl(wr_ctrl)
	);

	wr_line_buffer #(.LINE_WORDS(LINE_WORDS)) u_wr_line_buffer (
		.clk(clk),
		.rst(rst),
		.line_in(dc_wr_data),
		.word_in(dc_uncache_wr_data),
		.wdata(wdata),
		.ctrl(wr_ctrl)
	);

endmodule

`default_nettype wire

// File: sim/clk_gen.sv
`default_nettype none

module clk_gen #(
	parameter int HALF_NS = 20,
	parameter int RST_CYCLES = 16
) (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 1ps;

	initial
	begin
		clk = 1'b0;
		forever #(HALF_NS) clk = ~clk;
	end

	// reset released 1 ns after an edge like the other inputs
	initial
	begin
		rst = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#1 rst = 1'b1;
	end

endmodule

`default_nettype wire

// File: sim/axi_slave_model.sv
`default_nettype none

module axi_slave_model (
	input wire clk,
	input wire rst,
	input wire arvalid,
	input wire [3:0] arid,
	input wire [31:0] araddr,
	input wire [3:0] arlen,
	output logic arready,
	output logic [3:0] rid,
	output logic [31:0] rdata,
	output logic rlast,
	output logic rvalid,
	input wire rready,
	input wire awvalid,
	output logic awready,
	input wire wvalid,
	input wire wlast,
	output logic wready,
	output logic bvalid,
	input wire bready,
	output logic [7:0] ar_count,
	output logic [7:0] rlast_count,
	output logic [4:0] r_beat,
	output logic [4:0] w_count
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [31:0] rnd;
	logic [31:0] rd_base;
	logic [3:0] rd_len;
	logic rd_active;
	logic ar_fire;
	logic r_fire;
	logic r_end;
	logic aw_fire;
	logic w_fire;
	logic w_end;
	logic b_fire;
	logic [31:0] ar_addr_s;
	logic [3:0] ar_id_s;
	logic [3:0] ar_len_s;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	assign rdata = rd_base + {27'd0, r_beat}; // address plus beat index
	assign rlast = (r_beat == {1'b0, rd_len});

	initial
	begin
		rnd = 32'h5944;
		arready = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		rvalid = 1'b0;
		bvalid = 1'b0;
		rid = 4'd0;
		rd_base = 32'd0;
		rd_len = 4'd0;
		rd_active = 1'b0;
		ar_count = 8'd0;
		rlast_count = 8'd0;
		r_beat = 5'd0;
		w_count = 5'd0;
		forever
		begin
			// handshakes sampled mid cycle where all signals are settled
			@(negedge clk);
			ar_fire = rst && arvalid && arready;
			r_fire = rst && rvalid && rready;
			r_end = r_fire && rlast;
			aw_fire = rst && awvalid && awready;
			w_fire = rst && wvalid && wready;
			w_end = w_fire && wlast;
			b_fire = rst && bvalid && bready;
			ar_addr_s = araddr;
			ar_id_s = arid;
			ar_len_s = arlen;
			@(posedge clk);
			#1;
			if (r_fire)
				r_beat = r_beat + 5'd1;
			if (r_end)
			begin
				rd_active = 1'b0;
				rlast_count = rlast_count + 8'd1;
			end
			if (ar_fire)
			begin
				rd_active = 1'b1;
				rd_base = ar_addr_s;
				rd_len = ar_len_s;
				rid = ar_id_s;
				r_beat = 5'd0;
				ar_count = ar_count + 8'd1;
			end
			if (aw_fire)
				w_count = 5'd0;
			if (w_fire)
				w_count = w_count + 5'd1;
			if (b_fire)
				bvalid = 1'b0;
			if (w_end)
				bvalid = 1'b1; // response right after the last beat
			rnd = xorshift(rnd);
			arready = rnd[0] || rnd[1]; // stall about one cycle in four
			awready = rnd[2] || rnd[3];
			wready = rnd[4] || rnd[5];
			rvalid = rd_active && (rnd[6] || rnd[7]);
		end
	end

endmodule

`default_nettype wire

// File: sim/tb_axi_sram_bridge.sv
`default_nettype none

module tb_axi_sram_bridge;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int LINE_WORDS = 16;
	localparam int N_TRANS = 10;
	localparam logic [1:0] INCR = 2'b01;
	localparam logic [1:0] FIXED = 2'b00;
	localparam logic [3:0] LINE_LEN = 4'(LINE_WORDS - 1);

	wire clk;
	wire rst;
	logic conf_sel;
	wire [3:0] arid;
	wire [31:0] araddr;
	wire [3:0] arlen;
	wire [2:0] arsize;
	wire [1:0] arburst;
	wire [1:0] arlock;
	wire [3:0] arcache;
	wire [2:0] arprot;
	wire arvalid;
	wire arready;
	wire [3:0] rid;
	wire [31:0] rdata;
	wire rlast;
	wire rvalid;
	wire rready;
	wire [3:0] awid;
	wire [31:0] awaddr;
	wire [3:0] awlen;
	wire [2:0] awsize;
	wire [1:0] awburst;
	wire [1:0] awlock;
	wire [3:0] awcache;
	wire [2:0] awprot;
	wire awvalid;
	wire awready;
	wire [3:0] wid;
	wire [31:0] wdata;
	wire [3:0] wstrb;
	wire wlast;
	wire wvalid;
	wire wready;
	wire bvalid;
	wire bready;
	logic ic_rd_req;
	logic [31:0] ic_rd_addr;
	wire ic_rd_rdy;
	wire ic_ret_valid;
	wire ic_ret_last;
	wire [31:0] ic_ret_data;
	logic dc_rd_req;
	logic [31:0] dc_rd_addr;
	wire dc_rd_rdy;
	wire dc_ret_valid;
	wire dc_ret_last;
	wire [31:0] dc_ret_data;
	logic dc_wr_req;
	logic [31:0] dc_wr_addr;
	logic [3:0] dc_wr_wstrb;
	logic [LINE_WORDS*32-1:0] dc_wr_data;
	logic [31:0] dc_uncache_wr_data;
	wire dc_wr_rdy;
	wire [7:0] ar_count;
	wire [7:0] rlast_count;
	wire [4:0] r_beat;
	wire [4:0] w_count;

	logic [31:0] line_words [LINE_WORDS];
	logic started; // first request raised
	logic wr_single;
	logic [4:0] wr_beats;
	logic dc_single;
	logic [7:0] ic_ar_idx; // AR number expected for each port
	logic [7:0] dc_ar_idx;

	clk_gen #(.HALF_NS(20), .RST_CYCLES(16)) u_clk_gen (.*);

	axi_sram_bridge #(.LINE_WORDS(LINE_WORDS)) dut0 (.*);

	axi_slave_model u_slave (.*);

	always_comb
	begin
		for (int i = 0; i < LINE_WORDS; i++)
			dc_wr_data[i*32 +: 32] = line_words[i];
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "run stopped on the first error");
	endtask

	assert property (@(posedge clk) disable iff (!rst)
		!started |-> !arvalid && !awvalid && !wvalid && !ic_ret_valid && !dc_ret_valid)
		else stop_run($sformatf("MISMATCH at %0t: bus active before any request", $time));

	assert property (@(posedge clk) disable iff (!rst)
		rready && bready && awid == 4'd1 && wid == 4'd1
		&& arlock == 2'b00 && arcache == 4'b0000 && arprot == 3'b000
		&& awlock == 2'b00 && awcache == 4'b0000 && awprot == 3'b000)
		else stop_run($sformatf("MISMATCH at %0t: fixed AXI field wrong", $time));

	assert property (@(posedge clk) disable iff (!rst)
		awvalid && awready |-> awaddr == dc_wr_addr && awsize == 3'b010
		&& awlen == (wr_single ? 4'd0 : LINE_LEN) && awburst == (wr_single ? FIXED : INCR))
		else stop_run($sformatf("MISMATCH at %0t: AW fields wrong", $time));

	assert property (@(posedge clk) disable iff (!rst)
		wvalid && wready |-> wlast == (w_count == wr_beats - 5'd1)
		&& wdata == (wr_single ? dc_uncache_wr_data : line_words[w_count[3:0]]))
		else stop_run($sformatf("MISMATCH at %0t: W beat %0d data or wlast", $time, w_count));

	assert property (@(posedge clk) disable iff (!rst) wvalid |-> wstrb == dc_wr_wstrb)
		else stop_run($sformatf("MISMATCH at %0t: wstrb %h", $time, wstrb));

	// no beat beyond the burst and no response before the last beat
	assert property (@(posedge clk) disable iff (!rst) wvalid |-> w_count < wr_beats)
		else stop_run($sformatf("MISMATCH at %0t: extra W beat", $time));
	assert property (@(posedge clk) disable iff (!rst) bvalid |-> w_count == wr_beats)
		else stop_run($sformatf("MISMATCH at %0t: response before all beats", $time));

	assert property (@(posedge clk) disable iff (!rst) ic_rd_req |-> !dc_rd_rdy)
		else stop_run($sformatf("MISMATCH at %0t: dcache rdy while icache asks", $time));

	// next AR only once the previous burst has returned its last word
	assert property (@(posedge clk) disable iff (!rst)
		arvalid && arready |-> ar_count == rlast_count
		&& (ar_count == ic_ar_idx || ar_count == dc_ar_idx) && arsize == 3'b010)
		else stop_run($sformatf("MISMATCH at %0t: AR out of order", $time));

	assert property (@(posedge clk) disable iff (!rst)
		arvalid && arready && ar_count == ic_ar_idx
		|-> arid == 4'd0 && araddr == ic_rd_addr && arlen == LINE_LEN && arburst == INCR)
		else stop_run($sformatf("MISMATCH at %0t: icache AR fields", $time));

	assert property (@(posedge clk) disable iff (!rst)
		arvalid && arready && ar_count == dc_ar_idx |-> arid == 4'd1 && araddr == dc_rd_addr
		&& arlen == (dc_single ? 4'd0 : LINE_LEN) && arburst == (dc_single ? FIXED : INCR))
		else stop_run($sformatf("MISMATCH at %0t: dcache AR fields", $time));

	assert property (@(posedge clk) disable iff (!rst)
		rvalid |-> (rid[0] ? dc_ret_valid && !ic_ret_valid && dc_ret_data == rdata
		: ic_ret_valid && !dc_ret_valid && ic_ret_data == rdata))
		else stop_run($sformatf("MISMATCH at %0t: return routed to wrong port", $time));

	assert property (@(posedge clk) disable iff (!rst)
		!rvalid |-> !ic_ret_valid && !dc_ret_valid && !ic_ret_last && !dc_ret_last)
		else stop_run($sformatf("MISMATCH at %0t: return without rvalid", $time));

	assert property (@(posedge clk) disable iff (!rst)
		rvalid |-> (ic_ret_last || dc_ret_last) == rlast && !(ic_ret_last && dc_ret_last))
		else stop_run($sformatf("MISMATCH at %0t: ret_last apart from rlast", $time));

	assert property (@(posedge clk) disable iff (!rst)
		ic_ret_valid |-> ic_ret_data == ic_rd_addr + {27'd0, r_beat})
		else stop_run($sformatf("MISMATCH at %0t: icache word %0d", $time, r_beat));
	assert property (@(posedge clk) disable iff (!rst)
		dc_ret_valid |-> dc_ret_data == dc_rd_addr + {27'd0, r_beat})
		else stop_run($sformatf("MISMATCH at %0t: dcache word %0d", $time, r_beat));

	assert property (@(posedge clk) disable iff (!rst) ic_ret_last |-> r_beat == 5'd15)
		else stop_run($sformatf("MISMATCH at %0t: icache burst length", $time));
	assert property (@(posedge clk) disable iff (!rst)
		dc_ret_last |-> r_beat == (dc_single ? 5'd0 : 5'd15))
		else stop_run($sformatf("MISMATCH at %0t: dcache burst length", $time));

	task automatic send_write(input logic [31:0] addr, input logic single);
		logic done;
		dc_wr_addr = addr;
		wr_single = single;
		wr_beats = single ? 5'd1 : 5'(LINE_WORDS);
		for (int i = 0; i < LINE_WORDS; i++)
			line_words[i] = (addr + 32'(i) * 32'h0101_0101) ^ 32'hc3a5_0000;
		dc_uncache_wr_data = ~addr;
		dc_wr_wstrb = single ? 4'b0011 : 4'b1111;
		conf_sel = single;
		started = 1'b1;
		dc_wr_req = 1'b1;
		done = 1'b0;
		while (!done)
		begin
			@(negedge clk);
			done = dc_wr_rdy;
			@(posedge clk);
			#1;
		end
		dc_wr_req = 1'b0; // line stays put until the response
		done = 1'b0;
		while (!done)
		begin
			@(negedge clk);
			done = bvalid;
		end
		@(posedge clk);
		#1;
	endtask

	task automatic read_ports(input logic use_ic, input logic use_dc, input logic dc_conf,
		input logic [31:0] ia, input logic [31:0] da);
		int lasts;
		logic ic_take;
		logic dc_take;
		lasts = int'(use_ic) + int'(use_dc);
		ic_rd_addr = ia;
		dc_rd_addr = da;
		dc_single = dc_conf;
		conf_sel = dc_conf;
		ic_ar_idx = use_ic ? ar_count : 8'hff;
		dc_ar_idx = use_dc ? (use_ic ? ar_count + 8'd1 : ar_count) : 8'hff;
		started = 1'b1;
		ic_rd_req = use_ic;
		dc_rd_req = use_dc;
		while (ic_rd_req || dc_rd_req || lasts > 0)
		begin
			@(negedge clk);
			ic_take = ic_rd_req && ic_rd_rdy;
			dc_take = dc_rd_req && dc_rd_rdy;
			if (ic_ret_last)
				lasts--;
			if (dc_ret_last)
				lasts--;
			@(posedge clk);
			#1;
			if (ic_take)
				ic_rd_req = 1'b0;
			if (dc_take)
				dc_rd_req = 1'b0;
		end
	endtask

	// watchdog allows 200 cycles per transaction
	initial
	begin
		repeat (N_TRANS * 200 + 16) @(posedge clk);
		stop_run("timeout, the bridge stopped making progress");
	end

	initial
	begin
		conf_sel = 1'b0;
		ic_rd_req = 1'b0;
		ic_rd_addr = 32'd0;
		dc_rd_req = 1'b0;
		dc_rd_addr = 32'd0;
		dc_wr_req = 1'b0;
		dc_wr_addr = 32'd0;
		dc_wr_wstrb = 4'hf;
		dc_uncache_wr_data = 32'd0;
		for (int i = 0; i < LINE_WORDS; i++)
			line_words[i] = 32'd0;
		started = 1'b0;
		wr_single = 1'b0;
		wr_beats = 5'(LINE_WORDS);
		dc_single = 1'b0;
		ic_ar_idx = 8'hff;
		dc_ar_idx = 8'hff;
		wait (rst === 1'b1);
		repeat (4) @(posedge clk); // quiet bus after reset
		#1;
		send_write(32'h0000_1000, 1'b0);
		send_write(32'h1fd0_0010, 1'b1); // uncached
		send_write(32'h0000_2040, 1'b0);
		read_ports(1'b1, 1'b0, 1'b0, 32'h0000_3000, 32'h0);
		read_ports(1'b1, 1'b1, 1'b0, 32'h0000_4000, 32'h0000_5000);
		read_ports(1'b0, 1'b1, 1'b1, 32'h0, 32'h1fd0_0020);
		read_ports(1'b1, 1'b1, 1'b1, 32'h0000_6000, 32'h1fd0_0030);
		read_ports(1'b0, 1'b1, 1'b0, 32'h0, 32'h0000_7000);
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: axi_sram_bridge.f
logic/axi_bridge_pkg.sv
logic/cache_rd_if.sv
logic/wr_ctrl_if.sv
logic/rd_fsm.sv
logic/wr_fsm.sv
logic/beat_counter.sv
logic/wr_line_buffer.sv
logic/axi_sram_bridge.sv
sim/clk_gen.sv
sim/axi_slave_model.sv
sim/tb_axi_sram_bridge.sv

// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -sv --timescale 1ns/1ps \
		--top-module tb_axi_sram_bridge -Mdir obj_dir -f axi_sram_bridge.f

run: compile
	./obj_dir/Vtb_axi_sram_bridge

clean:
	rm -rf obj_dir
